//--- source/expipe_pkg.sv
// Pipeline sizing package
// ROB depth, ROB index type, register file geometry
// and the layout of one register status entry

`default_nettype none

package expipe_pkg;

  // --------------------
  // Reorder buffer
  // --------------------
  // Power of two so head and tail wrap without extra logic
  localparam int unsigned ROB_DEPTH = 8;
  localparam int unsigned ROB_IDX_W = $clog2(ROB_DEPTH);

  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  // --------------------
  // Registers and data
  // --------------------
  localparam int unsigned REG_NUM   = 32;
  localparam int unsigned REG_IDX_W = $clog2(REG_NUM);
  localparam int unsigned DATA_W    = 32;

  // In-flight writers of one register count up to ROB_DEPTH
  typedef logic [$clog2(ROB_DEPTH+1)-1:0] busy_cnt_t;

  // Status slot kept for every architectural register
  typedef struct packed {
    busy_cnt_t busy_cnt;
    rob_idx_t  rob_idx;
  } regstat_entry_t;

endpackage

`default_nettype wire

//--- source/instr_pkg.sv
// Instruction encoding package
// Operation codes and the 32-bit instruction word,
// whose payload is read either as two sources or as an immediate

`default_nettype none

package instr_pkg;

  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_XOR = 2'b10,
    OP_LI  = 2'b11
  } op_e;

  // Payload decoded by op
  // Register form for ADD/SUB/XOR, immediate form for LI
  typedef union packed {
    struct packed {
      logic [expipe_pkg::REG_IDX_W-1:0] rs1;
      logic [expipe_pkg::REG_IDX_W-1:0] rs2;
      logic [14:0]                      unused;
    } r;
    logic signed [24:0] imm;
  } payload_u;

  typedef struct packed {
    op_e                              op;
    logic [expipe_pkg::REG_IDX_W-1:0] rd;
    payload_u                         payload;
  } instr_t;

endpackage

`default_nettype wire

//--- source/fp_regstat.sv
// Register status table
// Per-register count of in-flight writers and ROB index of the youngest one,
// two combinational lookup ports for the issue unit

`timescale 1ns/1ps
`default_nettype none

module fp_regstat (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // Issue side
  input  logic                             issue_valid_i,
  input  logic [expipe_pkg::REG_IDX_W-1:0] issue_rd_idx_i,
  input  expipe_pkg::rob_idx_t             issue_rob_idx_i,
  input  logic [expipe_pkg::REG_IDX_W-1:0] issue_rs1_idx_i,
  input  logic [expipe_pkg::REG_IDX_W-1:0] issue_rs2_idx_i,
  output logic                             issue_rs1_busy_o,
  output expipe_pkg::rob_idx_t             issue_rs1_rob_idx_o,
  output logic                             issue_rs2_busy_o,
  output expipe_pkg::rob_idx_t             issue_rs2_rob_idx_o,
  // Commit side
  input  logic                             comm_valid_i,
  input  logic [expipe_pkg::REG_IDX_W-1:0] comm_rd_idx_i
);

  import expipe_pkg::*;

  regstat_entry_t regstat_q [REG_NUM];
  regstat_entry_t regstat_d [REG_NUM];

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    regstat_d = regstat_q;
    // Commit retires the oldest writer of rd
    if (comm_valid_i) begin
      regstat_d[comm_rd_idx_i].busy_cnt = regstat_q[comm_rd_idx_i].busy_cnt - 1'b1;
    end
    // Issue stacks on top of the commit result
    // Same register in both leaves the count as it was
    if (issue_valid_i) begin
      regstat_d[issue_rd_idx_i].busy_cnt = regstat_d[issue_rd_idx_i].busy_cnt + 1'b1;
      // Youngest writer always wins the index
      regstat_d[issue_rd_idx_i].rob_idx  = issue_rob_idx_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      foreach (regstat_q[i]) begin
        regstat_q[i] <= '0;
      end
    end else begin
      regstat_q <= regstat_d;
    end
  end

  // --------------------
  // Lookup ports
  // --------------------
  // Busy while any writer is still in the ROB
  assign issue_rs1_busy_o    = |regstat_q[issue_rs1_idx_i].busy_cnt;
  assign issue_rs1_rob_idx_o = regstat_q[issue_rs1_idx_i].rob_idx;
  assign issue_rs2_busy_o    = |regstat_q[issue_rs2_idx_i].busy_cnt;
  assign issue_rs2_rob_idx_o = regstat_q[issue_rs2_idx_i].rob_idx;

  // ROB capacity bounds the writers of one register
  a_cnt_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_i && !(comm_valid_i && comm_rd_idx_i == issue_rd_idx_i)
    |-> regstat_q[issue_rd_idx_i].busy_cnt < ROB_DEPTH);

  // Every commit matches an earlier issue to the same rd
  a_cnt_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    comm_valid_i |-> regstat_q[comm_rd_idx_i].busy_cnt != '0);

endmodule

`default_nettype wire

//--- source/reorder_buffer.sv
// Reorder buffer
// Circular entry store with tail allocation, writeback by tag,
// two source read ports and in-order commit from the head

`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // Allocation from issue
  input  logic                             alloc_valid_i,
  input  logic [expipe_pkg::REG_IDX_W-1:0] alloc_rd_i,
  output expipe_pkg::rob_idx_t             alloc_idx_o,
  output logic                             full_o,
  // Writeback from the exec pipe
  input  logic                             wb_valid_i,
  input  expipe_pkg::rob_idx_t             wb_rob_idx_i,
  input  logic [expipe_pkg::DATA_W-1:0]    wb_data_i,
  // Source read ports
  input  expipe_pkg::rob_idx_t             rd1_idx_i,
  output logic                             rd1_done_o,
  output logic [expipe_pkg::DATA_W-1:0]    rd1_data_o,
  input  expipe_pkg::rob_idx_t             rd2_idx_i,
  output logic                             rd2_done_o,
  output logic [expipe_pkg::DATA_W-1:0]    rd2_data_o,
  // Commit stream, always accepted
  output logic                             commit_valid_o,
  output logic [expipe_pkg::REG_IDX_W-1:0] commit_rd_o,
  output logic [expipe_pkg::DATA_W-1:0]    commit_data_o
);

  import expipe_pkg::*;

  localparam int unsigned CNT_W = ROB_IDX_W + 1;

  // Entry payload
  logic [REG_IDX_W-1:0] rd_q   [ROB_DEPTH];
  logic [DATA_W-1:0]    data_q [ROB_DEPTH];

  // Entry state and pointers
  logic [ROB_DEPTH-1:0] valid_q;
  logic [ROB_DEPTH-1:0] done_q;
  rob_idx_t             head_q;
  rob_idx_t             tail_q;
  logic [CNT_W-1:0]     cnt_q;

  // --------------------
  // Control state
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      done_q  <= '0;
      head_q  <= '0;
      tail_q  <= '0;
      cnt_q   <= '0;
    end else begin
      // New entry waits for its result
      if (alloc_valid_i) begin
        valid_q[tail_q] <= 1'b1;
        done_q[tail_q]  <= 1'b0;
        tail_q          <= tail_q + 1'b1;
      end
      if (wb_valid_i) begin
        done_q[wb_rob_idx_i] <= 1'b1;
      end
      // Head leaves as soon as it is done
      if (commit_valid_o) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
      end
      case ({alloc_valid_i, commit_valid_o})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // --------------------
  // Payload
  // --------------------
  always_ff @(posedge clk_i) begin
    if (alloc_valid_i) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (wb_valid_i) begin
      data_q[wb_rob_idx_i] <= wb_data_i;
    end
  end

  assign alloc_idx_o = tail_q;
  assign full_o      = (cnt_q == CNT_W'(ROB_DEPTH));

  // Source forwarding reads
  assign rd1_done_o = done_q[rd1_idx_i];
  assign rd1_data_o = data_q[rd1_idx_i];
  assign rd2_done_o = done_q[rd2_idx_i];
  assign rd2_data_o = data_q[rd2_idx_i];

  // Commit
  assign commit_valid_o = valid_q[head_q] & done_q[head_q];
  assign commit_rd_o    = rd_q[head_q];
  assign commit_data_o  = data_q[head_q];

  // Issue must have seen full and held off
  a_no_alloc_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alloc_valid_i |-> !full_o);

  // Exec pipe tags only point at live, pending entries
  a_wb_live_entry: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_i |-> valid_q[wb_rob_idx_i] && !done_q[wb_rob_idx_i]);

endmodule

`default_nettype wire

//--- source/exec_pipe.sv
// Execution pipe
// ALU for ADD, SUB, XOR and LI in the first stage,
// then EXEC_LAT register stages carrying valid, ROB tag and result

`timescale 1ns/1ps
`default_nettype none

module exec_pipe #(
  parameter int unsigned EXEC_LAT = 3
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          in_valid_i,
  input  instr_pkg::op_e                in_op_i,
  input  logic [expipe_pkg::DATA_W-1:0] in_a_i,
  input  logic [expipe_pkg::DATA_W-1:0] in_b_i,
  input  expipe_pkg::rob_idx_t          in_rob_idx_i,
  output logic                          out_valid_o,
  output expipe_pkg::rob_idx_t          out_rob_idx_o,
  output logic [expipe_pkg::DATA_W-1:0] out_data_o
);

  import expipe_pkg::*;
  import instr_pkg::*;

  logic [DATA_W-1:0]   alu_res;
  logic [EXEC_LAT-1:0] vld_q;
  rob_idx_t            tag_q [EXEC_LAT];
  logic [DATA_W-1:0]   res_q [EXEC_LAT];

  // --------------------
  // ALU
  // --------------------
  // Add and sub wrap around, LI takes the prepared immediate
  always_comb begin
    case (in_op_i)
      OP_ADD:  alu_res = in_a_i + in_b_i;
      OP_SUB:  alu_res = in_a_i - in_b_i;
      OP_XOR:  alu_res = in_a_i ^ in_b_i;
      default: alu_res = in_b_i;
    endcase
  end

  // --------------------
  // Stage registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= in_valid_i;
      for (int i = 1; i < EXEC_LAT; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // Tag and result shift alongside valid
  always_ff @(posedge clk_i) begin
    tag_q[0] <= in_rob_idx_i;
    res_q[0] <= alu_res;
    for (int i = 1; i < EXEC_LAT; i++) begin
      tag_q[i] <= tag_q[i-1];
      res_q[i] <= res_q[i-1];
    end
  end

  // Last stage is the writeback
  assign out_valid_o   = vld_q[EXEC_LAT-1];
  assign out_rob_idx_o = tag_q[EXEC_LAT-1];
  assign out_data_o    = res_q[EXEC_LAT-1];

endmodule

`default_nettype wire

//--- source/issue_unit.sv
// Issue unit
// Decodes the instruction, picks each source from the register file
// or a done ROB entry, stalls on pending sources or a full ROB

`timescale 1ns/1ps
`default_nettype none

module issue_unit (
  // Instruction port
  input  logic                             instr_valid_i,
  input  instr_pkg::instr_t                instr_i,
  output logic                             instr_ready_o,
  // Register status lookup
  output logic [expipe_pkg::REG_IDX_W-1:0] rs1_idx_o,
  output logic [expipe_pkg::REG_IDX_W-1:0] rs2_idx_o,
  input  logic                             rs1_busy_i,
  input  expipe_pkg::rob_idx_t             rs1_rob_idx_i,
  input  logic                             rs2_busy_i,
  input  expipe_pkg::rob_idx_t             rs2_rob_idx_i,
  // Register file data
  input  logic [expipe_pkg::DATA_W-1:0]    rf_rs1_data_i,
  input  logic [expipe_pkg::DATA_W-1:0]    rf_rs2_data_i,
  // ROB source reads
  output expipe_pkg::rob_idx_t             rob_rd1_idx_o,
  input  logic                             rob_rd1_done_i,
  input  logic [expipe_pkg::DATA_W-1:0]    rob_rd1_data_i,
  output expipe_pkg::rob_idx_t             rob_rd2_idx_o,
  input  logic                             rob_rd2_done_i,
  input  logic [expipe_pkg::DATA_W-1:0]    rob_rd2_data_i,
  input  logic                             rob_full_i,
  // Dispatch to ROB and exec pipe
  output logic                             disp_valid_o,
  output instr_pkg::op_e                   disp_op_o,
  output logic [expipe_pkg::REG_IDX_W-1:0] disp_rd_o,
  output logic [expipe_pkg::DATA_W-1:0]    disp_a_o,
  output logic [expipe_pkg::DATA_W-1:0]    disp_b_o
);

  import expipe_pkg::*;
  import instr_pkg::*;

  logic              is_li;
  logic              src1_ok;
  logic              src2_ok;
  logic              srcs_ok;
  logic [DATA_W-1:0] src1_val;
  logic [DATA_W-1:0] src2_val;
  logic [DATA_W-1:0] imm_ext;

  // --------------------
  // Decode and lookup
  // --------------------
  assign is_li     = (instr_i.op == OP_LI);
  assign rs1_idx_o = instr_i.payload.r.rs1;
  assign rs2_idx_o = instr_i.payload.r.rs2;

  // Youngest writer's entry is the forwarding source
  assign rob_rd1_idx_o = rs1_rob_idx_i;
  assign rob_rd2_idx_o = rs2_rob_idx_i;

  // Source ready with no writer in the ROB or with its writer done
  assign src1_ok = !rs1_busy_i || rob_rd1_done_i;
  assign src2_ok = !rs2_busy_i || rob_rd2_done_i;
  assign srcs_ok = is_li || (src1_ok && src2_ok);

  assign src1_val = rs1_busy_i ? rob_rd1_data_i : rf_rs1_data_i;
  assign src2_val = rs2_busy_i ? rob_rd2_data_i : rf_rs2_data_i;

  // Signed cast widens with the sign bit
  assign imm_ext = DATA_W'(instr_i.payload.imm);

  // --------------------
  // Handshake and dispatch
  // --------------------
  // Ready never looks at valid
  assign instr_ready_o = !rob_full_i && srcs_ok;
  assign disp_valid_o  = instr_valid_i && instr_ready_o;
  assign disp_op_o     = instr_i.op;
  assign disp_rd_o     = instr_i.rd;
  assign disp_a_o      = src1_val;
  assign disp_b_o      = is_li ? imm_ext : src2_val;

endmodule

`default_nettype wire

//--- source/fp_regfile.sv
// Architectural register file
// 32 registers cleared at reset, one commit write port,
// two combinational read ports

`timescale 1ns/1ps
`default_nettype none

module fp_regfile (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             we_i,
  input  logic [expipe_pkg::REG_IDX_W-1:0] waddr_i,
  input  logic [expipe_pkg::DATA_W-1:0]    wdata_i,
  input  logic [expipe_pkg::REG_IDX_W-1:0] raddr1_i,
  output logic [expipe_pkg::DATA_W-1:0]    rdata1_o,
  input  logic [expipe_pkg::REG_IDX_W-1:0] raddr2_i,
  output logic [expipe_pkg::DATA_W-1:0]    rdata2_o
);

  import expipe_pkg::*;

  logic [DATA_W-1:0] regs_q [REG_NUM];

  // Register 0 is writable like any other
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      foreach (regs_q[i]) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];

endmodule

`default_nettype wire

//--- source/expipe_top.sv
// Execution pipeline top level
// Issue unit, register status table, ROB, exec pipe and register file,
// instruction port in and commit stream out

`timescale 1ns/1ps
`default_nettype none

module expipe_top #(
  parameter int unsigned EXEC_LAT = 3
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             instr_valid_i,
  input  instr_pkg::instr_t                instr_i,
  output logic                             instr_ready_o,
  output logic                             commit_valid_o,
  output logic [expipe_pkg::REG_IDX_W-1:0] commit_rd_o,
  output logic [expipe_pkg::DATA_W-1:0]    commit_data_o
);

  import expipe_pkg::*;
  import instr_pkg::*;

  // --------------------
  // Interconnect
  // --------------------
  // Source lookups
  logic [REG_IDX_W-1:0] rs1_idx, rs2_idx;
  logic                 rs1_busy, rs2_busy;
  rob_idx_t             rs1_rob_idx, rs2_rob_idx;
  logic [DATA_W-1:0]    rf_rs1_data, rf_rs2_data;
  rob_idx_t             rob_rd1_idx, rob_rd2_idx;
  logic                 rob_rd1_done, rob_rd2_done;
  logic [DATA_W-1:0]    rob_rd1_data, rob_rd2_data;
  logic                 rob_full;
  // Dispatch
  logic                 disp_valid;
  op_e                  disp_op;
  logic [REG_IDX_W-1:0] disp_rd;
  logic [DATA_W-1:0]    disp_a, disp_b;
  rob_idx_t             alloc_idx;
  // Writeback
  logic                 wb_valid;
  rob_idx_t             wb_rob_idx;
  logic [DATA_W-1:0]    wb_data;
  // Commit
  logic                 commit_valid;
  logic [REG_IDX_W-1:0] commit_rd;
  logic [DATA_W-1:0]    commit_data;

  issue_unit u_issue (
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_ready_o  (instr_ready_o),
    .rs1_idx_o      (rs1_idx),
    .rs2_idx_o      (rs2_idx),
    .rs1_busy_i     (rs1_busy),
    .rs1_rob_idx_i  (rs1_rob_idx),
    .rs2_busy_i     (rs2_busy),
    .rs2_rob_idx_i  (rs2_rob_idx),
    .rf_rs1_data_i  (rf_rs1_data),
    .rf_rs2_data_i  (rf_rs2_data),
    .rob_rd1_idx_o  (rob_rd1_idx),
    .rob_rd1_done_i (rob_rd1_done),
    .rob_rd1_data_i (rob_rd1_data),
    .rob_rd2_idx_o  (rob_rd2_idx),
    .rob_rd2_done_i (rob_rd2_done),
    .rob_rd2_data_i (rob_rd2_data),
    .rob_full_i     (rob_full),
    .disp_valid_o   (disp_valid),
    .disp_op_o      (disp_op),
    .disp_rd_o      (disp_rd),
    .disp_a_o       (disp_a),
    .disp_b_o       (disp_b)
  );

  // Records rd against the tail entry on dispatch
  fp_regstat u_regstat (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .issue_valid_i       (disp_valid),
    .issue_rd_idx_i      (disp_rd),
    .issue_rob_idx_i     (alloc_idx),
    .issue_rs1_idx_i     (rs1_idx),
    .issue_rs2_idx_i     (rs2_idx),
    .issue_rs1_busy_o    (rs1_busy),
    .issue_rs1_rob_idx_o (rs1_rob_idx),
    .issue_rs2_busy_o    (rs2_busy),
    .issue_rs2_rob_idx_o (rs2_rob_idx),
    .comm_valid_i        (commit_valid),
    .comm_rd_idx_i       (commit_rd)
  );

  reorder_buffer u_rob (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .alloc_valid_i  (disp_valid),
    .alloc_rd_i     (disp_rd),
    .alloc_idx_o    (alloc_idx),
    .full_o         (rob_full),
    .wb_valid_i     (wb_valid),
    .wb_rob_idx_i   (wb_rob_idx),
    .wb_data_i      (wb_data),
    .rd1_idx_i      (rob_rd1_idx),
    .rd1_done_o     (rob_rd1_done),
    .rd1_data_o     (rob_rd1_data),
    .rd2_idx_i      (rob_rd2_idx),
    .rd2_done_o     (rob_rd2_done),
    .rd2_data_o     (rob_rd2_data),
    .commit_valid_o (commit_valid),
    .commit_rd_o    (commit_rd),
    .commit_data_o  (commit_data)
  );

  // Tag is the tail entry allocated at dispatch
  exec_pipe #(
    .EXEC_LAT (EXEC_LAT)
  ) u_exec (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (disp_valid),
    .in_op_i       (disp_op),
    .in_a_i        (disp_a),
    .in_b_i        (disp_b),
    .in_rob_idx_i  (alloc_idx),
    .out_valid_o   (wb_valid),
    .out_rob_idx_o (wb_rob_idx),
    .out_data_o    (wb_data)
  );

  fp_regfile u_regfile (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .we_i     (commit_valid),
    .waddr_i  (commit_rd),
    .wdata_i  (commit_data),
    .raddr1_i (rs1_idx),
    .rdata1_o (rf_rs1_data),
    .raddr2_i (rs2_idx),
    .rdata2_o (rf_rs2_data)
  );

  // Commit stream mirrored outside
  assign commit_valid_o = commit_valid;
  assign commit_rd_o    = commit_rd;
  assign commit_data_o  = commit_data;

endmodule

`default_nettype wire

//--- tb/tb_clkgen.sv
// Testbench clock and reset source
// Free-running clock, active-low reset held for a few cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int unsigned PERIOD_NS  = 8,
  parameter int unsigned RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
    end
  end

  // Release on a falling edge, away from the DUT's sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb/tb_expipe.sv
// Testbench for the execution pipeline
// Directed and random instruction table, looped driver on falling edges,
// in-order commit checker backed by a reference register model

`timescale 1ns/1ps
`default_nettype none

module tb_expipe;

  import expipe_pkg::*;
  import instr_pkg::*;

  // Long latency so a burst fills the ROB
  localparam int unsigned EXEC_LAT       = 9;
  localparam int unsigned N_BURST        = 12;
  localparam int unsigned N_RANDOM       = 40;
  localparam int unsigned RESET_TIMEOUT  = 20;
  localparam int unsigned READY_TIMEOUT  = 200;
  localparam int unsigned COMMIT_TIMEOUT = 200;
  localparam int unsigned QUIET_CYCLES   = 40;
  localparam logic [31:0] SEED           = 32'h50ec_c5f4;

  logic                 clk;
  logic                 rst_n;
  logic                 instr_valid;
  instr_t               instr;
  logic                 instr_ready;
  logic                 commit_valid;
  logic [REG_IDX_W-1:0] commit_rd;
  logic [DATA_W-1:0]    commit_data;

  // Stimulus table, one row per instruction in program order
  instr_t               tab_instr [$];
  logic [REG_IDX_W-1:0] tab_rd    [$];
  logic [DATA_W-1:0]    tab_data  [$];
  int unsigned          tab_gap   [$];

  // Architectural state as the reference model sees it
  logic [DATA_W-1:0]    ref_regs [REG_NUM];

  int burst_lo;
  int burst_hi;
  int burst_stalls;

  tb_clkgen #(
    .PERIOD_NS  (8),
    .RST_CYCLES (3)
  ) u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  expipe_top #(
    .EXEC_LAT (EXEC_LAT)
  ) UUT (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .instr_ready_o  (instr_ready),
    .commit_valid_o (commit_valid),
    .commit_rd_o    (commit_rd),
    .commit_data_o  (commit_data)
  );

  // --------------------
  // Failure reporting
  // --------------------
  task automatic stop_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic abort_run(string why);
    $display("%0t ns: %s", $time, why);
    stop_run();
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    stop_run();
  endtask

  // --------------------
  // Table building
  // --------------------
  function automatic instr_t reg_instr(op_e op, int rd, int rs1, int rs2);
    instr_t w;
    w               = '0;
    w.op            = op;
    w.rd            = rd[REG_IDX_W-1:0];
    w.payload.r.rs1 = rs1[REG_IDX_W-1:0];
    w.payload.r.rs2 = rs2[REG_IDX_W-1:0];
    return w;
  endfunction

  function automatic instr_t li_instr(int rd, int imm);
    instr_t w;
    w             = '0;
    w.op          = OP_LI;
    w.rd          = rd[REG_IDX_W-1:0];
    w.payload.imm = imm[24:0];
    return w;
  endfunction

  // In-order reference ALU on the model registers
  function automatic logic [DATA_W-1:0] model_result(instr_t w);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    a = ref_regs[w.payload.r.rs1];
    b = ref_regs[w.payload.r.rs2];
    case (w.op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_XOR:  return a ^ b;
      default: return {{(DATA_W-25){w.payload.imm[24]}}, w.payload.imm};
    endcase
  endfunction

  // Model register follows every row so random rows see directed results
  task automatic add_row(instr_t w, logic [DATA_W-1:0] exp_data, int unsigned gap);
    tab_instr.push_back(w);
    tab_rd.push_back(w.rd);
    tab_data.push_back(exp_data);
    tab_gap.push_back(gap);
    ref_regs[w.rd] = exp_data;
  endtask

  task automatic build_table();
    int unsigned rnd;
    instr_t      w;
    // Sign extension at the positive and negative extremes
    add_row(li_instr(1, 5), 32'h0000_0005, 0);
    add_row(li_instr(2, -3), 32'hFFFF_FFFD, 0);
    add_row(li_instr(3, 16777215), 32'h00FF_FFFF, 0);
    add_row(li_instr(4, -16777216), 32'hFF00_0000, 0);
    // Dependent chain back to back with sources forwarded from the ROB
    add_row(reg_instr(OP_ADD, 5, 1, 2), 32'h0000_0002, 0);
    add_row(reg_instr(OP_SUB, 6, 5, 1), 32'hFFFF_FFFD, 0);
    add_row(reg_instr(OP_XOR, 7, 6, 3), 32'hFF00_0002, 0);
    add_row(reg_instr(OP_ADD, 8, 7, 7), 32'hFE00_0004, 0);
    add_row(reg_instr(OP_SUB, 9, 1, 4), 32'h0100_0005, 0);
    add_row(reg_instr(OP_ADD, 12, 4, 4), 32'hFE00_0000, 0);
    // Long gap lets the sources retire to the register file
    add_row(reg_instr(OP_ADD, 13, 1, 2), 32'h0000_0002, 16);
    // Two writers of r10 and readers of the younger one
    add_row(li_instr(10, 100), 32'h0000_0064, 0);
    add_row(li_instr(10, 7), 32'h0000_0007, 0);
    add_row(reg_instr(OP_ADD, 11, 10, 10), 32'h0000_000E, 0);
    add_row(reg_instr(OP_XOR, 14, 10, 11), 32'h0000_0009, 0);
    // Burst longer than the ROB with valid held high
    burst_lo = tab_instr.size();
    for (int k = 0; k < N_BURST; k++) begin
      add_row(li_instr(16 + k, 'h111 * (k + 1)), 32'h111 * (k + 1), 0);
    end
    burst_hi = tab_instr.size() - 1;
    // Random words are legal for every op since unused bits are ignored
    for (int k = 0; k < N_RANDOM; k++) begin
      rnd = $urandom();
      w   = instr_t'(rnd);
      add_row(w, model_result(w), $urandom_range(3, 0));
    end
  endtask

  // --------------------
  // Driver and checkers
  // --------------------
  task automatic wait_reset();
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    #1;
    while (!rst_n) begin
      waited++;
      assert (waited < RESET_TIMEOUT)
        else abort_run("reset was never released");
      @(negedge clk);
      #1;
    end
  endtask

  // Entered on a falling edge and left on the falling edge after the transfer
  task automatic offer_row(int idx);
    int unsigned waited;
    for (int g = 0; g < int'(tab_gap[idx]); g++) begin
      instr_valid = 1'b0;
      @(negedge clk);
    end
    instr_valid = 1'b1;
    instr       = tab_instr[idx];
    waited      = 0;
    // Ready settles after the drive and holds until the rising edge
    #1;
    while (!instr_ready) begin
      if (idx >= burst_lo && idx <= burst_hi) begin
        burst_stalls++;
      end
      waited++;
      assert (waited < READY_TIMEOUT)
        else abort_run($sformatf("instruction port never became ready for row %0d", idx));
      @(negedge clk);
      #1;
    end
    @(negedge clk);
  endtask

  task automatic drive_rows();
    @(negedge clk);
    for (int i = 0; i < tab_instr.size(); i++) begin
      offer_row(i);
    end
    instr_valid = 1'b0;
  endtask

  // Commit outputs come from ROB state only and are stable at the falling edge
  task automatic check_commits();
    int unsigned waited;
    for (int k = 0; k < tab_instr.size(); k++) begin
      waited = 0;
      @(negedge clk);
      while (!commit_valid) begin
        waited++;
        assert (waited < COMMIT_TIMEOUT)
          else abort_run($sformatf("row %0d did not commit in time", k));
        @(negedge clk);
      end
      assert (commit_rd === tab_rd[k])
        else report_mismatch("commit_rd_o", 32'(commit_rd), 32'(tab_rd[k]));
      assert (commit_data === tab_data[k])
        else report_mismatch("commit_data_o", commit_data, tab_data[k]);
    end
  endtask

  task automatic check_quiet();
    for (int c = 0; c < QUIET_CYCLES; c++) begin
      @(negedge clk);
      assert (commit_valid === 1'b0)
        else abort_run("commit seen after the last instruction retired");
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    instr_valid  = 1'b0;
    instr        = '0;
    burst_stalls = 0;
    void'($urandom(SEED));
    foreach (ref_regs[r]) begin
      ref_regs[r] = '0;
    end
    build_table();
    wait_reset();
    // Idle pipeline out of reset
    assert (commit_valid === 1'b0)
      else report_mismatch("commit_valid_o", 32'(commit_valid), 32'd0);
    assert (instr_ready === 1'b1)
      else report_mismatch("instr_ready_o", 32'(instr_ready), 32'd1);
    fork
      drive_rows();
      check_commits();
    join
    check_quiet();
    assert (burst_stalls > 0)
      else abort_run("instruction port never stalled during the burst");
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
source/expipe_pkg.sv
source/instr_pkg.sv
source/fp_regstat.sv
source/reorder_buffer.sv
source/exec_pipe.sv
source/issue_unit.sv
source/fp_regfile.sv
source/expipe_top.sv
tb/tb_clkgen.sv
tb/tb_expipe.sv

//--- Bender.yml
package:
  name: expipe

sources:
  # Packages ahead of the modules that import them
  - source/expipe_pkg.sv
  - source/instr_pkg.sv
  - source/fp_regstat.sv
  - source/reorder_buffer.sv
  - source/exec_pipe.sv
  - source/issue_unit.sv
  - source/fp_regfile.sv
  - source/expipe_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/tb_expipe.sv
